//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int XLEN     = 64;
   localparam int REG_AW   = 5;
   localparam int OP_SEL_W = 2;
   localparam int ALU_OPW  = 3;

   // Writeback source select
   localparam logic WB_ALU  = 1'b0;
   localparam logic WB_LINK = 1'b1;

   // ------------------------------
   // Major opcodes
   // ------------------------------
   typedef enum logic [6:0] {
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011,
      OP_LUI    = 7'b0110111,
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111
   } opcode_e;

   // Operand b source
   typedef enum logic [OP_SEL_W-1:0] {
      OPS_REG   = 2'd0, // rs2
      OPS_IMM12 = 2'd1, // I-type immediate
      OPS_IMM20 = 2'd2, // LUI upper immediate
      OPS_PC    = 2'd3  // Link address pc+4
   } op_sel_e;

   // ------------------------------
   // Execute functions
   // ------------------------------
   typedef enum logic [ALU_OPW-1:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5,
      ALU_BEQ = 3'd6,
      ALU_BNE = 3'd7
   } alu_op_e;

   // funct3 codes used by the decoder
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;

endpackage

`default_nettype wire

//--- rtl/dec_exe_if.sv
`default_nettype none

interface dec_exe_if;
   import rv_pkg::*;

   logic              valid;
   logic              rf_we;
   logic [REG_AW-1:0] rd;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   op_sel_e           op_sel;
   alu_op_e           fu_sel;
   logic              wb_sel;  // WB_ALU or WB_LINK
   logic [11:0]       imm12;
   logic [12:0]       imm13;
   logic [19:0]       imm20;
   logic [20:0]       imm21;
   logic [XLEN-1:0]   pc;
   logic [31:0]       insn;

   modport src (
      output valid, rf_we, rd, rs1_addr, rs2_addr,
      output op_sel, fu_sel, wb_sel,
      output imm12, imm13, imm20, imm21,
      output pc, insn
   );

   modport dst (
      input valid, rf_we, rd, rs1_addr, rs2_addr,
      input op_sel, fu_sel, wb_sel,
      input imm12, imm13, imm20, imm21,
      input pc, insn
   );

endinterface

`default_nettype wire

//--- rtl/rv_decoder.sv
`default_nettype none

module rv_decoder (
   input  logic                    insn_valid,
   input  logic [31:0]             insn,
   input  logic [rv_pkg::XLEN-1:0] pc,
   dec_exe_if.src                  dec
);
   import rv_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       legal;

   assign opcode = opcode_e'(insn[6:0]);
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];

   // ------------------------------
   // Immediates and register fields
   // ------------------------------
   assign dec.imm12    = insn[31:20];
   assign dec.imm13    = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
   assign dec.imm20    = insn[31:12];
   assign dec.imm21    = {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
   assign dec.rd       = insn[11:7];
   assign dec.rs2_addr = insn[24:20];
   assign dec.pc       = pc;
   assign dec.insn     = insn;

   // LUI and JAL use bits 19:15 as immediate, so rs1 reads x0
   assign dec.rs1_addr = (opcode == OP_LUI || opcode == OP_JAL) ? '0 : insn[19:15];

   assign dec.valid = insn_valid & legal;

   // ------------------------------
   // Control fields
   // ------------------------------
   always_comb
   begin
      legal      = 1'b0;
      dec.rf_we  = 1'b0;
      dec.op_sel = OPS_REG;
      dec.fu_sel = ALU_ADD;
      dec.wb_sel = WB_ALU;
      case (opcode)
         OP_IMM:
         begin
            legal      = (funct3 == F3_ADD); // ADDI only
            dec.rf_we  = 1'b1;
            dec.op_sel = OPS_IMM12;
         end
         OP_REG:
         begin
            dec.rf_we = 1'b1;
            legal     = (funct7 == 7'b0000000);
            case (funct3)
               F3_ADD:
               begin
                  legal      = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                  dec.fu_sel = funct7[5] ? ALU_SUB : ALU_ADD;
               end
               F3_AND:  dec.fu_sel = ALU_AND;
               F3_OR:   dec.fu_sel = ALU_OR;
               F3_XOR:  dec.fu_sel = ALU_XOR;
               F3_SLT:  dec.fu_sel = ALU_SLT;
               default: legal = 1'b0;
            endcase
         end
         OP_LUI:
         begin
            legal      = 1'b1;
            dec.rf_we  = 1'b1;
            dec.op_sel = OPS_IMM20;
         end
         OP_BRANCH:
         begin
            legal      = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            dec.fu_sel = (funct3 == F3_BNE) ? ALU_BNE : ALU_BEQ;
         end
         OP_JAL:
         begin
            legal      = 1'b1;
            dec.rf_we  = 1'b1;
            dec.op_sel = OPS_PC;
            dec.wb_sel = WB_LINK;
         end
         default: legal = 1'b0; // Loads, stores, system and the rest
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/idu_exu.sv
`default_nettype none

module idu_exu (
   input  logic    clk,
   input  logic    rst,
   input  logic    flush,
   dec_exe_if.dst  dec,
   dec_exe_if.src  exe
);
   import rv_pkg::*;

   // ------------------------------
   // Control fields
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         exe.valid  <= 1'b0;
         exe.rf_we  <= 1'b0;
         exe.op_sel <= OPS_REG;
         exe.fu_sel <= ALU_ADD;
         exe.wb_sel <= WB_ALU;
      end
      else
      begin
         // Flush kills the younger instruction
         exe.valid  <= flush ? 1'b0 : dec.valid;
         exe.rf_we  <= flush ? 1'b0 : dec.rf_we;
         exe.op_sel <= flush ? OPS_REG : dec.op_sel;
         exe.fu_sel <= flush ? ALU_ADD : dec.fu_sel;
         exe.wb_sel <= flush ? WB_ALU : dec.wb_sel;
      end
   end

   // ------------------------------
   // Data fields
   // ------------------------------
   always_ff @(posedge clk)
   begin
      exe.rd       <= dec.rd;
      exe.rs1_addr <= dec.rs1_addr;
      exe.rs2_addr <= dec.rs2_addr;
      exe.imm12    <= dec.imm12;
      exe.imm13    <= dec.imm13;
      exe.imm20    <= dec.imm20;
      exe.imm21    <= dec.imm21;
      exe.pc       <= dec.pc;
      exe.insn     <= dec.insn;
   end

endmodule

`default_nettype wire

//--- rtl/rv_exec.sv
`default_nettype none

module rv_exec (
   input  logic                      clk,
   input  logic                      rst,
   dec_exe_if.dst                    exe,
   output logic                      flush,
   output logic                      wb_valid,
   output logic [rv_pkg::REG_AW-1:0] wb_rd,
   output logic [rv_pkg::XLEN-1:0]   wb_data,
   output logic                      redirect_valid,
   output logic [rv_pkg::XLEN-1:0]   redirect_pc
);
   import rv_pkg::*;

   logic [XLEN-1:0] regs [1:31]; // x0 not stored
   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] result;
   logic [XLEN-1:0] target;
   logic            equal;
   logic            taken;
   logic            wb_we;

   // ------------------------------
   // Operand fetch
   // ------------------------------
   assign op_a = (exe.rs1_addr == '0) ? '0 : regs[exe.rs1_addr];

   always_comb
   begin
      case (exe.op_sel)
         OPS_REG:   op_b = (exe.rs2_addr == '0) ? '0 : regs[exe.rs2_addr];
         OPS_IMM12: op_b = {{52{exe.imm12[11]}}, exe.imm12};
         OPS_IMM20: op_b = {{32{exe.imm20[19]}}, exe.imm20, 12'b0};
         default:   op_b = exe.pc + 64'd4; // Link address
      endcase
   end

   // ------------------------------
   // ALU and branch resolution
   // ------------------------------
   assign equal = (op_a == op_b);

   always_comb
   begin
      case (exe.fu_sel)
         ALU_ADD: alu_res = op_a + op_b;
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_XOR: alu_res = op_a ^ op_b;
         ALU_SLT: alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
         ALU_BEQ: alu_res = {63'b0, equal};
         default: alu_res = {63'b0, ~equal}; // BNE
      endcase
   end

   assign taken = ((exe.fu_sel == ALU_BEQ) && equal) || ((exe.fu_sel == ALU_BNE) && !equal);
   assign flush = exe.valid & (taken | (exe.wb_sel == WB_LINK));

   assign target = (exe.wb_sel == WB_LINK) ? exe.pc + {{43{exe.imm21[20]}}, exe.imm21}
                                           : exe.pc + {{51{exe.imm13[12]}}, exe.imm13};

   assign result = (exe.wb_sel == WB_LINK) ? op_b : alu_res;
   assign wb_we  = exe.valid & exe.rf_we & (exe.rd != '0);

   // ------------------------------
   // Writeback and redirect
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (wb_we)
         regs[exe.rd] <= result;
      wb_rd       <= exe.rd;
      wb_data     <= result;
      redirect_pc <= target;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wb_valid       <= 1'b0;
         redirect_valid <= 1'b0;
      end
      else
      begin
         wb_valid       <= wb_we;
         redirect_valid <= flush;
      end
   end

endmodule

`default_nettype wire

//--- rtl/rv_slice_top.sv
`default_nettype none

module rv_slice_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      insn_valid,
   input  logic [31:0]               insn,
   input  logic [rv_pkg::XLEN-1:0]   pc,
   output logic                      wb_valid,
   output logic [rv_pkg::REG_AW-1:0] wb_rd,
   output logic [rv_pkg::XLEN-1:0]   wb_data,
   output logic                      redirect_valid,
   output logic [rv_pkg::XLEN-1:0]   redirect_pc
);

   logic flush; // Taken branch or JAL in execute

   dec_exe_if dec_q ();
   dec_exe_if exe_q ();

   rv_decoder rv_decoder_i (
      .insn_valid (insn_valid),
      .insn       (insn),
      .pc         (pc),
      .dec        (dec_q.src)
   );

   idu_exu idu_exu_i (
      .clk   (clk),
      .rst   (rst),
      .flush (flush),
      .dec   (dec_q.dst),
      .exe   (exe_q.src)
   );

   rv_exec rv_exec_i (
      .clk            (clk),
      .rst            (rst),
      .exe            (exe_q.dst),
      .flush          (flush),
      .wb_valid       (wb_valid),
      .wb_rd          (wb_rd),
      .wb_data        (wb_data),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

endmodule

`default_nettype wire

//--- tb/rv_slice_asserts.sv
`default_nettype none

module rv_slice_asserts (
   input logic                      clk,
   input logic                      rst,
   input logic                      wb_valid,
   input logic [rv_pkg::REG_AW-1:0] wb_rd,
   input logic [rv_pkg::XLEN-1:0]   wb_data,
   input logic                      redirect_valid,
   input logic [rv_pkg::XLEN-1:0]   redirect_pc
);
   timeunit 1ns;
   timeprecision 1ns;

   int fail_count = 0;

   // Idle in reset and the cycle after
   assert property (@(posedge clk) rst |=> !wb_valid && !redirect_valid)
   else
   begin
      $error("valid output set right after a reset cycle");
      fail_count++;
   end

   assert property (@(posedge clk) $fell(rst) |=> !wb_valid && !redirect_valid)
   else
   begin
      $error("valid output set one cycle after reset");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != '0)
   else
   begin
      $error("writeback to x0");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (rst)
                    wb_valid |-> !$isunknown({wb_rd, wb_data}))
   else
   begin
      $error("unknown writeback value");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (rst)
                    redirect_valid |-> !$isunknown(redirect_pc))
   else
   begin
      $error("unknown redirect pc");
      fail_count++;
   end

endmodule

bind rv_slice_top rv_slice_asserts asserts_i (.*);

`default_nettype wire

//--- tb/rv_slice_checker.sv
`default_nettype none

module rv_slice_checker (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      insn_valid,
   input  logic [31:0]               insn,
   input  logic [rv_pkg::XLEN-1:0]   pc,
   input  logic                      group_end,
   input  logic                      wb_valid,
   input  logic [rv_pkg::REG_AW-1:0] wb_rd,
   input  logic [rv_pkg::XLEN-1:0]   wb_data,
   input  logic                      redirect_valid,
   input  logic [rv_pkg::XLEN-1:0]   redirect_pc,
   output int                        errors,
   output int                        groups_done,
   output int                        groups_failed
);
   timeunit 1ns;
   timeprecision 1ns;
   import rv_pkg::*;

   logic [XLEN-1:0] mregs [0:31];
   logic            ex_v;         // Instruction in execute
   logic            ex_end;
   logic [31:0]     ex_insn;
   logic [XLEN-1:0] ex_pc;
   logic            exp_wb;       // Expected after next edge
   logic            exp_rv;
   logic            exp_end;
   logic [4:0]      exp_rd;
   logic [XLEN-1:0] exp_data;
   logic [XLEN-1:0] exp_rpc;
   int              grp_errors;

   function automatic logic is_legal(input logic [31:0] i);
      logic [2:0] f3;
      logic [6:0] f7;
      f3 = i[14:12];
      f7 = i[31:25];
      case (i[6:0])
         OP_IMM:    return f3 == 3'b000;
         OP_REG:    return (f7 == 7'h00 && f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111})
                           || (f7 == 7'h20 && f3 == 3'b000);
         OP_LUI:    return 1'b1;
         OP_JAL:    return 1'b1;
         OP_BRANCH: return f3 inside {3'b000, 3'b001};
         default:   return 1'b0;
      endcase
   endfunction

   task automatic check_outputs;
      if (wb_valid !== exp_wb || redirect_valid !== exp_rv)
      begin
         $display("Fail %0t: wb_valid %b redirect_valid %b, expected %b %b",
                  $time, wb_valid, redirect_valid, exp_wb, exp_rv);
         grp_errors++;
      end
      if (exp_wb && (wb_rd !== exp_rd || wb_data !== exp_data))
      begin
         $display("Fail %0t: writeback x%0d = %h, expected x%0d = %h",
                  $time, wb_rd, wb_data, exp_rd, exp_data);
         grp_errors++;
      end
      if (exp_rv && redirect_pc !== exp_rpc)
      begin
         $display("Fail %0t: redirect_pc %h, expected %h", $time, redirect_pc, exp_rpc);
         grp_errors++;
      end
   endtask

   task automatic report_group;
      if (grp_errors == 0)
         $display("test %0d passed", groups_done);
      else
      begin
         $display("test %0d failed with %0d errors", groups_done, grp_errors);
         groups_failed++;
      end
      errors += grp_errors;
      grp_errors = 0;
      groups_done++;
   endtask

   // ------------------------------
   // Execute stage model
   // ------------------------------
   task automatic execute;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [2:0]      f3;
      logic            wr;
      f3       = ex_insn[14:12];
      a        = mregs[ex_insn[19:15]];
      b        = mregs[ex_insn[24:20]];
      wr       = 1'b1;
      exp_rv   = 1'b0;
      exp_data = '0;
      exp_rpc  = '0;
      case (ex_insn[6:0])
         OP_IMM: exp_data = a + {{52{ex_insn[31]}}, ex_insn[31:20]};
         OP_REG:
            case (f3)
               3'b000:  exp_data = ex_insn[30] ? a - b : a + b;
               3'b111:  exp_data = a & b;
               3'b110:  exp_data = a | b;
               3'b100:  exp_data = a ^ b;
               default: exp_data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0; // SLT
            endcase
         OP_LUI: exp_data = {{32{ex_insn[31]}}, ex_insn[31:12], 12'h000};
         OP_BRANCH:
         begin
            wr      = 1'b0;
            exp_rv  = (f3 == 3'b001) ? (a != b) : (a == b);
            exp_rpc = ex_pc + {{51{ex_insn[31]}}, ex_insn[31], ex_insn[7], ex_insn[30:25],
                               ex_insn[11:8], 1'b0};
         end
         default: // JAL
         begin
            exp_data = ex_pc + 64'd4;
            exp_rv   = 1'b1;
            exp_rpc  = ex_pc + {{43{ex_insn[31]}}, ex_insn[31], ex_insn[19:12], ex_insn[20],
                                ex_insn[30:21], 1'b0};
         end
      endcase
      exp_rd = ex_insn[11:7];
      exp_wb = ex_v && wr && exp_rd != 5'd0;
      exp_rv = ex_v && exp_rv;
      if (exp_wb)
         mregs[exp_rd] = exp_data;
   endtask

   always @(negedge clk)
   begin
      if (rst)
      begin
         for (int r = 0; r < 32; r++)
            mregs[r] = '0;
         ex_v          = 1'b0;
         ex_end        = 1'b0;
         exp_wb        = 1'b0;
         exp_rv        = 1'b0;
         exp_end       = 1'b0;
         grp_errors    = 0;
         errors        = 0;
         groups_done   = 0;
         groups_failed = 0;
      end
      else
      begin
         check_outputs();
         if (exp_end)
            report_group();
         exp_end = ex_end;
         execute();
         ex_v    = insn_valid && is_legal(insn) && !exp_rv; // Killed by a redirect
         ex_end  = group_end;
         ex_insn = insn;
         ex_pc   = pc;
      end
   end

endmodule

`default_nettype wire

//--- tb/rv_slice_tb.sv
`default_nettype none

module rv_slice_tb;
   timeunit 1ns;
   timeprecision 1ns;
   import rv_pkg::*;

   localparam int RESET_CYCLES = 3;

   typedef struct packed {
      logic            valid;
      logic            group_end;
      logic [31:0]     insn;
      logic [XLEN-1:0] pc;
   } stim_t;

   logic              clk = 1'b0;
   logic              rst;
   logic              insn_valid;
   logic [31:0]       insn;
   logic [XLEN-1:0]   pc;
   logic              group_end;
   logic              wb_valid;
   logic [REG_AW-1:0] wb_rd;
   logic [XLEN-1:0]   wb_data;
   logic              redirect_valid;
   logic [XLEN-1:0]   redirect_pc;
   int                errors;
   int                groups_done;
   int                groups_failed;

   stim_t           stim [$];
   logic [XLEN-1:0] next_pc = 64'h1000;
   int              n_groups = 0;
   int              cycles = 0;
   int              limit = 0;
   integer          seed = 32'h759f;

   always #50 clk = ~clk;

   rv_slice_top rv_slice_top_i (.*);

   rv_slice_checker checker_i (.*);

   // ------------------------------
   // Instruction encoders
   // ------------------------------
   function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   task automatic add_insn(input logic v, input logic [31:0] i);
      stim.push_back('{v, 1'b0, i, next_pc});
      next_pc += 4;
   endtask

   // Bubble that marks the end of a group
   task automatic close_group;
      stim.push_back('{1'b0, 1'b1, 32'h0, next_pc});
      n_groups++;
   endtask

   task automatic fill_stimulus;
      logic [31:0] rnd;
      for (int r = 1; r <= 4; r++)
      begin
         rnd = $random(seed);
         add_insn(1'b1, itype(rnd[11:0], 5'd0, 3'b000, r[4:0], OP_IMM));
      end
      rnd = $random(seed);
      add_insn(1'b1, itype(rnd[11:0], 5'd1, 3'b000, 5'd5, OP_IMM));
      close_group();
      add_insn(1'b1, rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));  // ADD
      add_insn(1'b1, rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd7));  // SUB
      add_insn(1'b1, rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd8));  // AND
      add_insn(1'b1, rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd9));  // OR
      add_insn(1'b1, rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd10)); // XOR
      add_insn(1'b1, rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd11)); // SLT
      add_insn(1'b1, rtype(7'h00, 5'd1, 5'd2, 3'b010, 5'd12));
      add_insn(1'b1, {20'hfedcb, 5'd13, OP_LUI});
      close_group();
      add_insn(1'b1, itype(12'd5, 5'd0, 3'b000, 5'd14, OP_IMM));
      add_insn(1'b1, itype(12'd7, 5'd14, 3'b000, 5'd14, OP_IMM)); // Reads x14 just written
      add_insn(1'b1, rtype(7'h00, 5'd14, 5'd14, 3'b000, 5'd15));
      add_insn(1'b1, itype(12'd9, 5'd1, 3'b000, 5'd0, OP_IMM));   // x0 target
      add_insn(1'b1, rtype(7'h00, 5'd1, 5'd0, 3'b000, 5'd16));
      close_group();
      add_insn(1'b1, btype(13'd16, 5'd14, 5'd14, 3'b000));        // BEQ taken
      add_insn(1'b1, itype(12'd1, 5'd0, 3'b000, 5'd17, OP_IMM));
      add_insn(1'b1, btype(13'd8, 5'd14, 5'd14, 3'b001));         // BNE not taken
      add_insn(1'b1, itype(12'd2, 5'd0, 3'b000, 5'd18, OP_IMM));
      add_insn(1'b1, btype(13'h1ff8, 5'd15, 5'd14, 3'b001));      // Backward BNE
      add_insn(1'b1, itype(12'd3, 5'd0, 3'b000, 5'd19, OP_IMM));
      add_insn(1'b1, btype(13'd12, 5'd15, 5'd14, 3'b000));
      close_group();
      add_insn(1'b1, jtype(21'd2048, 5'd20));
      add_insn(1'b1, itype(12'd4, 5'd0, 3'b000, 5'd21, OP_IMM));
      add_insn(1'b1, jtype(21'h1fffc0, 5'd0));                    // Back 64, no link
      add_insn(1'b1, itype(12'd5, 5'd0, 3'b000, 5'd22, OP_IMM));
      close_group();
      add_insn(1'b1, itype(12'd0, 5'd1, 3'b011, 5'd23, 7'b0000011)); // LD
      add_insn(1'b1, {7'd0, 5'd2, 5'd1, 3'b011, 5'd0, 7'b0100011}); // SD
      add_insn(1'b1, itype(12'd1, 5'd1, 3'b001, 5'd24, OP_IMM));     // SLLI
      add_insn(1'b1, rtype(7'h20, 5'd2, 5'd1, 3'b111, 5'd25));
      add_insn(1'b0, itype(12'd6, 5'd0, 3'b000, 5'd26, OP_IMM));     // Not valid
      close_group();
   endtask

   // ------------------------------
   // Timeout
   // ------------------------------
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout: run did not finish");
         $display("TB FAILED");
         $finish;
      end
   end

   initial
   begin
      rst        = 1'b1;
      insn_valid = 1'b0;
      insn       = '0;
      pc         = '0;
      group_end  = 1'b0;
      fill_stimulus();
      limit = stim.size() + RESET_CYCLES + 10;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      foreach (stim[k])
      begin
         insn_valid <= stim[k].valid;
         group_end  <= stim[k].group_end;
         insn       <= stim[k].insn;
         pc         <= stim[k].pc;
         @(posedge clk);
      end
      insn_valid <= 1'b0;
      group_end  <= 1'b0;
      while (groups_done < n_groups)
         @(posedge clk);
      $display("tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
               groups_done, groups_failed, errors, rv_slice_top_i.asserts_i.fail_count);
      if (errors == 0 && groups_failed == 0 && rv_slice_top_i.asserts_i.fail_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
rtl/rv_pkg.sv
rtl/dec_exe_if.sv
rtl/rv_decoder.sv
rtl/idu_exu.sv
rtl/rv_exec.sv
rtl/rv_slice_top.sv
tb/rv_slice_asserts.sv
tb/rv_slice_checker.sv
tb/rv_slice_tb.sv

//--- Bender.yml
package:
  name: rv_slice

sources:
  - rtl/rv_pkg.sv
  - rtl/dec_exe_if.sv
  - rtl/rv_decoder.sv
  - rtl/idu_exu.sv
  - rtl/rv_exec.sv
  - rtl/rv_slice_top.sv
  - target: test
    files:
      - tb/rv_slice_asserts.sv
      - tb/rv_slice_checker.sv
      - tb/rv_slice_tb.sv
